// File: Makefile
VERILATOR ?= verilator
TB_TOP    ?= tb_mem_wb
RTL_TOP   ?= mem_wb_top
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --assert --timing
PASS_MSG  := TEST RESULT: PASS

.PHONY: all lint lint_rtl sim clean

all: sim

lint: lint_rtl
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

lint_rtl:
	$(VERILATOR) --lint-only $(VFLAGS) +incdir+logic \
		logic/mips_pkg.sv logic/stage_if.sv logic/data_memory.sv \
		logic/mem_wb_reg.sv logic/reg_bank.sv logic/mem_wb_top.sv \
		--top-module $(RTL_TOP)

$(OBJ_DIR)/V$(TB_TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(OBJ_DIR) -o V$(TB_TOP)

sim: $(OBJ_DIR)/V$(TB_TOP)
	./$(OBJ_DIR)/V$(TB_TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: files.f
+incdir+logic
logic/mips_pkg.sv
logic/stage_if.sv
logic/data_memory.sv
logic/mem_wb_reg.sv
logic/reg_bank.sv
logic/mem_wb_top.sv
test/tb_mem_wb.sv

// File: logic/data_memory.sv
`timescale 1ns/1ns
`include "mips_defs.svh"

module data_memory
    import mips_pkg::*;
(
    input  logic        i_clock,
    input  logic        i_reset,
    input  logic        i_pipeline_enable,
    input  logic        i_mem_read,
    input  logic        i_mem_write,
    input  mem_op_e     i_mem_op,
    input  data_t       i_alu_result,       // byte address
    input  data_t       i_store_data,
    input  logic        i_reg_write,
    input  logic        i_mem_to_reg,
    input  reg_addr_t   i_selected_reg,
    input  logic        i_r31_ctrl,
    input  pc_t         i_pc,
    input  logic        i_hlt,
    stage_if.src        o_stage
);

    localparam int ADDR_BITS = $clog2(`MEM_BYTES);

    logic [7:0]             mem [`MEM_BYTES];
    logic [ADDR_BITS-1:0]   addr;
    logic [ADDR_BITS-1:0]   lane_addr [4];
    logic [7:0]             rd_byte [4];
    data_t                  load_val;
    logic                   store_en;
    logic                   misaligned;

    assign addr     = i_alu_result[ADDR_BITS-1:0];  // modulo memory size
    assign store_en = i_mem_write && i_pipeline_enable;

    // little endian, lane i sits at addr + i
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            lane_addr[i] = addr + ADDR_BITS'(i);
            rd_byte[i]   = mem[lane_addr[i]];
        end
    end

    always_comb begin
        case (i_mem_op)
            MEM_BYTE:   load_val = {{(`NB_DATA-8){rd_byte[0][7]}}, rd_byte[0]};
            MEM_BYTE_U: load_val = {{(`NB_DATA-8){1'b0}}, rd_byte[0]};
            MEM_HALF:   load_val = {{(`NB_DATA-16){rd_byte[1][7]}}, rd_byte[1], rd_byte[0]};
            MEM_HALF_U: load_val = {{(`NB_DATA-16){1'b0}}, rd_byte[1], rd_byte[0]};
            default:    load_val = {rd_byte[3], rd_byte[2], rd_byte[1], rd_byte[0]};
        endcase
    end

    always_comb begin
        case (i_mem_op)
            MEM_HALF, MEM_HALF_U: misaligned = addr[0];
            MEM_WORD:             misaligned = |addr[1:0];
            default:              misaligned = 1'b0;
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            for (int i = 0; i < `MEM_BYTES; i++) begin
                mem[i] <= 8'd0;
            end
        end else if (store_en) begin
            mem[lane_addr[0]] <= i_store_data[7:0];
            if (i_mem_op inside {MEM_HALF, MEM_HALF_U, MEM_WORD}) begin
                mem[lane_addr[1]] <= i_store_data[15:8];
            end
            if (i_mem_op == MEM_WORD) begin
                mem[lane_addr[2]] <= i_store_data[23:16];
                mem[lane_addr[3]] <= i_store_data[31:24];
            end
        end
    end

    assign o_stage.mem_data     = i_mem_read ? load_val : '0;
    assign o_stage.reg_write    = i_reg_write;
    assign o_stage.mem_to_reg   = i_mem_to_reg;
    assign o_stage.alu_result   = i_alu_result;
    assign o_stage.selected_reg = i_selected_reg;
    assign o_stage.r31_ctrl     = i_r31_ctrl;
    assign o_stage.pc           = i_pc;
    assign o_stage.hlt          = i_hlt;

    // decode upstream never issues both
    a_rw_exclusive: assert property (
        @(posedge i_clock) disable iff (i_reset)
            !(i_mem_read && i_mem_write)
    ) else $error("data_memory: read and write in the same cycle");

    a_aligned: assert property (
        @(posedge i_clock) disable iff (i_reset)
            (i_mem_read || i_mem_write) |-> !misaligned
    ) else $error("data_memory: misaligned access at %0h", i_alu_result);

endmodule

// File: logic/mem_wb_reg.sv
`timescale 1ns/1ns

module mem_wb_reg (
    input  logic    i_clock,
    input  logic    i_reset,
    input  logic    i_pipeline_enable,  // low while debug unit stalls
    stage_if.dst    i_mem,
    stage_if.src    o_wb
);

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_wb.reg_write    <= 1'b0;
            o_wb.mem_to_reg   <= 1'b0;
            o_wb.mem_data     <= '0;
            o_wb.alu_result   <= '0;
            o_wb.selected_reg <= '0;
            o_wb.r31_ctrl     <= 1'b0;
            o_wb.pc           <= '0;
            o_wb.hlt          <= 1'b0;
        end else if (i_pipeline_enable) begin
            o_wb.reg_write    <= i_mem.reg_write;
            o_wb.mem_to_reg   <= i_mem.mem_to_reg;
            o_wb.mem_data     <= i_mem.mem_data;
            o_wb.alu_result   <= i_mem.alu_result;
            o_wb.selected_reg <= i_mem.selected_reg;
            o_wb.r31_ctrl     <= i_mem.r31_ctrl;
            o_wb.pc           <= i_mem.pc;
            o_wb.hlt          <= i_mem.hlt;
        end
    end

    // stalled stage keeps its instruction intact
    a_hold_on_stall: assert property (
        @(posedge i_clock) disable iff (i_reset)
            !i_pipeline_enable |=> $stable({
                o_wb.reg_write,
                o_wb.mem_to_reg,
                o_wb.mem_data,
                o_wb.alu_result,
                o_wb.selected_reg,
                o_wb.r31_ctrl,
                o_wb.pc,
                o_wb.hlt
            })
    ) else $error("mem_wb_reg: contents changed during stall");

endmodule

// File: logic/mem_wb_top.sv
`timescale 1ns/1ns

module mem_wb_top
    import mips_pkg::*;
(
    input  logic        i_clock,
    input  logic        i_reset,
    input  logic        i_pipeline_enable,
    input  logic        i_mem_read,
    input  logic        i_mem_write,
    input  mem_op_e     i_mem_op,
    input  data_t       i_alu_result,
    input  data_t       i_store_data,
    input  logic        i_reg_write,
    input  logic        i_mem_to_reg,
    input  reg_addr_t   i_selected_reg,
    input  logic        i_r31_ctrl,
    input  pc_t         i_pc,
    input  logic        i_hlt,
    input  reg_addr_t   i_rs_addr,
    input  reg_addr_t   i_rt_addr,
    output data_t       o_rs_data,
    output data_t       o_rt_data,
    output logic        o_wb_reg_write,
    output reg_addr_t   o_wb_reg,
    output data_t       o_wb_data,
    output logic        o_halted
);

    stage_if mem_q ();      // memory stage out
    stage_if wb_q ();       // write-back stage in

    data_memory u_data_memory (
        .i_clock            (i_clock),
        .i_reset            (i_reset),
        .i_pipeline_enable  (i_pipeline_enable),
        .i_mem_read         (i_mem_read),
        .i_mem_write        (i_mem_write),
        .i_mem_op           (i_mem_op),
        .i_alu_result       (i_alu_result),
        .i_store_data       (i_store_data),
        .i_reg_write        (i_reg_write),
        .i_mem_to_reg       (i_mem_to_reg),
        .i_selected_reg     (i_selected_reg),
        .i_r31_ctrl         (i_r31_ctrl),
        .i_pc               (i_pc),
        .i_hlt              (i_hlt),
        .o_stage            (mem_q.src)
    );

    mem_wb_reg u_mem_wb_reg (
        .i_clock            (i_clock),
        .i_reset            (i_reset),
        .i_pipeline_enable  (i_pipeline_enable),
        .i_mem              (mem_q.dst),
        .o_wb               (wb_q.src)
    );

    reg_bank u_reg_bank (
        .i_clock            (i_clock),
        .i_reset            (i_reset),
        .i_pipeline_enable  (i_pipeline_enable),
        .i_wb               (wb_q.dst),
        .i_rs_addr          (i_rs_addr),
        .i_rt_addr          (i_rt_addr),
        .o_rs_data          (o_rs_data),
        .o_rt_data          (o_rt_data),
        .o_wb_reg_write     (o_wb_reg_write),
        .o_wb_reg           (o_wb_reg),
        .o_wb_data          (o_wb_data),
        .o_halted           (o_halted)
    );

endmodule

// File: logic/mips_defs.svh
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// datapath widths
`define NB_DATA     32
`define NB_REG      5
`define NB_PC       32

// data memory size in bytes, address wraps modulo this
`define MEM_BYTES   1024

`endif

// File: logic/mips_pkg.sv
`include "mips_defs.svh"

package mips_pkg;

    typedef logic [`NB_DATA-1:0] data_t;        // register and memory word
    typedef logic [`NB_REG-1:0]  reg_addr_t;    // register index
    typedef logic [`NB_PC-1:0]   pc_t;

    // access width of a load or store
    // unsigned variants only matter for loads
    typedef enum logic [2:0] {
        MEM_BYTE   = 3'd0,  // lb / sb
        MEM_BYTE_U = 3'd1,  // lbu
        MEM_HALF   = 3'd2,  // lh / sh
        MEM_HALF_U = 3'd3,  // lhu
        MEM_WORD   = 3'd4   // lw / sw
    } mem_op_e;

endpackage

// File: logic/reg_bank.sv
`timescale 1ns/1ns

module reg_bank
    import mips_pkg::*;
(
    input  logic        i_clock,
    input  logic        i_reset,
    input  logic        i_pipeline_enable,
    stage_if.dst        i_wb,
    input  reg_addr_t   i_rs_addr,
    input  reg_addr_t   i_rt_addr,
    output data_t       o_rs_data,
    output data_t       o_rt_data,
    output logic        o_wb_reg_write,
    output reg_addr_t   o_wb_reg,
    output data_t       o_wb_data,
    output logic        o_halted
);

    localparam int        NUM_REGS = 2 ** $bits(reg_addr_t);
    localparam reg_addr_t LINK_REG = reg_addr_t'(31);  // ra

    data_t      regs [NUM_REGS];
    data_t      wb_value;
    reg_addr_t  wb_dest;
    logic       wb_en;
    logic       halted;

    // write-back mux
    always_comb begin
        if (i_wb.r31_ctrl) begin
            wb_value = data_t'(i_wb.pc);    // pc already holds return address
        end else if (i_wb.mem_to_reg) begin
            wb_value = i_wb.mem_data;
        end else begin
            wb_value = i_wb.alu_result;
        end
    end

    assign wb_dest = i_wb.r31_ctrl ? LINK_REG : i_wb.selected_reg;
    assign wb_en   = i_wb.reg_write && i_pipeline_enable && (wb_dest != '0);

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb_dest] <= wb_value;
        end
    end

    // write-through so a read in the same cycle sees the pending value
    assign o_rs_data = (wb_en && (i_rs_addr == wb_dest)) ? wb_value : regs[i_rs_addr];
    assign o_rt_data = (wb_en && (i_rt_addr == wb_dest)) ? wb_value : regs[i_rt_addr];

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            halted <= 1'b0;
        end else if (i_pipeline_enable && i_wb.hlt) begin
            halted <= 1'b1;     // sticky until reset
        end
    end

    assign o_halted       = halted;
    assign o_wb_reg_write = i_wb.reg_write;
    assign o_wb_reg       = wb_dest;
    assign o_wb_data      = wb_value;

    // r0 hardwired, bypass included
    a_r0_zero: assert property (
        @(posedge i_clock) disable iff (i_reset)
            ((i_rs_addr != '0) || (o_rs_data == '0)) &&
            ((i_rt_addr != '0) || (o_rt_data == '0))
    ) else $error("reg_bank: register 0 read nonzero");

endmodule

// File: logic/stage_if.sv
`timescale 1ns/1ns

interface stage_if
    import mips_pkg::*;
();

    logic       reg_write;      // bubble when low
    logic       mem_to_reg;     // wb mux select
    data_t      mem_data;       // loaded value, extended
    data_t      alu_result;
    reg_addr_t  selected_reg;
    logic       r31_ctrl;       // link instruction
    pc_t        pc;             // return address for link
    logic       hlt;

    modport src (
        output reg_write,
        output mem_to_reg,
        output mem_data,
        output alu_result,
        output selected_reg,
        output r31_ctrl,
        output pc,
        output hlt
    );

    modport dst (
        input reg_write,
        input mem_to_reg,
        input mem_data,
        input alu_result,
        input selected_reg,
        input r31_ctrl,
        input pc,
        input hlt
    );

endinterface

// File: test/tb_mem_wb.sv
`timescale 1ns/1ns
`include "mips_defs.svh"

module tb_mem_wb
    import mips_pkg::*;
();

    localparam int ADDR_BITS    = $clog2(`MEM_BYTES);
    localparam int TEST_CYCLES  = 40 + 55 + 100 + 20 + 25 + 30;  // per-test lengths
    localparam int TIMEOUT_NS   = TEST_CYCLES * 20 * 10;

    typedef struct packed {
        logic       we;
        reg_addr_t  dest;
        data_t      val;
        logic       hlt;
    } wb_exp_t;

    logic       i_clock;
    logic       i_reset;
    logic       i_pipeline_enable;
    logic       i_mem_read;
    logic       i_mem_write;
    mem_op_e    i_mem_op;
    data_t      i_alu_result;
    data_t      i_store_data;
    logic       i_reg_write;
    logic       i_mem_to_reg;
    reg_addr_t  i_selected_reg;
    logic       i_r31_ctrl;
    pc_t        i_pc;
    logic       i_hlt;
    reg_addr_t  i_rs_addr;
    reg_addr_t  i_rt_addr;
    data_t      o_rs_data;
    data_t      o_rt_data;
    logic       o_wb_reg_write;
    reg_addr_t  o_wb_reg;
    data_t      o_wb_data;
    logic       o_halted;

    // reference model state
    logic [7:0] mmem [`MEM_BYTES];
    data_t      mregs [32];
    logic       mhalted;
    wb_exp_t    wb_expected [$];

    logic [31:0] seed = 32'hf2aa_e2d6;
    string       cur_test = "init";
    int          errors = 0;
    int          checks = 0;
    int          test_errs_start;
    int          tests_run = 0;
    int          tests_failed = 0;
    reg_addr_t   last_sel = '0;

    mem_wb_top dut (.*);

    initial begin
        i_clock = 1'b0;
        forever #5 i_clock = ~i_clock;
    end

    initial begin
        i_reset           = 1'b1;
        i_pipeline_enable = 1'b1;
        i_mem_read        = 1'b0;
        i_mem_write       = 1'b0;
        i_mem_op          = MEM_WORD;
        i_alu_result      = '0;
        i_store_data      = '0;
        i_reg_write       = 1'b0;
        i_mem_to_reg      = 1'b0;
        i_selected_reg    = '0;
        i_r31_ctrl        = 1'b0;
        i_pc              = '0;
        i_hlt             = 1'b0;
        i_rs_addr         = '0;
        i_rt_addr         = '0;
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic data_t aligned_addr(mem_op_e op);
        data_t r;
        r = lcg_next() & 32'h0000_03fc;
        if (op == MEM_BYTE || op == MEM_BYTE_U) begin
            r = r + data_t'(seed[17:16]);
        end else if (op == MEM_HALF || op == MEM_HALF_U) begin
            r = r + data_t'({seed[17], 1'b0});
        end
        return r;
    endfunction

    // expected write-back of one instruction from the model memory
    function automatic wb_exp_t ref_wb(logic rd, mem_op_e op, data_t alu, logic rw, logic m2r,
                                       reg_addr_t sel, logic r31, pc_t pc, logic hlt);
        wb_exp_t                r;
        data_t                  ld;
        logic [ADDR_BITS-1:0]   a;
        logic [7:0]             b0, b1, b2, b3;
        a  = alu[ADDR_BITS-1:0];
        b0 = mmem[a];
        b1 = mmem[a + ADDR_BITS'(1)];
        b2 = mmem[a + ADDR_BITS'(2)];
        b3 = mmem[a + ADDR_BITS'(3)];
        case (op)
            MEM_BYTE:   ld = {{24{b0[7]}}, b0};
            MEM_BYTE_U: ld = {24'd0, b0};
            MEM_HALF:   ld = {{16{b1[7]}}, b1, b0};
            MEM_HALF_U: ld = {16'd0, b1, b0};
            default:    ld = {b3, b2, b1, b0};
        endcase
        if (!rd) ld = '0;
        r.we   = rw;
        r.dest = r31 ? reg_addr_t'(31) : sel;
        r.val  = r31 ? data_t'(pc) : (m2r ? ld : alu);
        r.hlt  = hlt;
        return r;
    endfunction

    task automatic model_store(mem_op_e op, data_t alu, data_t sd);
        logic [ADDR_BITS-1:0] a;
        a = alu[ADDR_BITS-1:0];
        mmem[a] = sd[7:0];
        if (op != MEM_BYTE && op != MEM_BYTE_U) mmem[a + ADDR_BITS'(1)] = sd[15:8];
        if (op == MEM_WORD) begin
            mmem[a + ADDR_BITS'(2)] = sd[23:16];
            mmem[a + ADDR_BITS'(3)] = sd[31:24];
        end
    endtask

    task automatic check_val(string what, data_t exp, data_t act);
        checks++;
        if (exp !== act) begin
            $display("ERROR %s %s: expected %h actual %h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    // samples outputs before the edge updates them
    always @(posedge i_clock) begin : compare
        wb_exp_t e;
        logic    pw;
        data_t   rs_e;
        data_t   rt_e;
        if (i_reset) begin
            for (int i = 0; i < 32; i++) mregs[i] = '0;
            for (int i = 0; i < `MEM_BYTES; i++) mmem[i] = 8'd0;
            mhalted = 1'b0;
            wb_expected.delete();
            wb_expected.push_back('0);
        end else begin
            e = wb_expected[0];
            check_val("o_wb_reg_write", data_t'(e.we), data_t'(o_wb_reg_write));
            if (e.we) begin
                check_val("o_wb_reg", data_t'(e.dest), data_t'(o_wb_reg));
                check_val("o_wb_data", e.val, o_wb_data);
            end
            check_val("o_halted", data_t'(mhalted), data_t'(o_halted));
            pw   = e.we && i_pipeline_enable && (e.dest != '0);
            rs_e = (pw && i_rs_addr == e.dest) ? e.val : mregs[i_rs_addr];
            rt_e = (pw && i_rt_addr == e.dest) ? e.val : mregs[i_rt_addr];
            check_val("o_rs_data", rs_e, o_rs_data);
            check_val("o_rt_data", rt_e, o_rt_data);
            if (i_pipeline_enable) begin
                if (pw) mregs[e.dest] = e.val;
                if (e.hlt) mhalted = 1'b1;
                void'(wb_expected.pop_front());
                wb_expected.push_back(ref_wb(i_mem_read, i_mem_op, i_alu_result, i_reg_write,
                                             i_mem_to_reg, i_selected_reg, i_r31_ctrl, i_pc,
                                             i_hlt));
                if (i_mem_write) model_store(i_mem_op, i_alu_result, i_store_data);
            end
        end
    end

    task automatic present(logic en, logic rd, logic wr, mem_op_e op, data_t alu, data_t sd,
                           logic rw, logic m2r, reg_addr_t sel, logic r31, pc_t pc, logic hlt);
        @(posedge i_clock);
        i_pipeline_enable <= en;
        i_mem_read        <= rd;
        i_mem_write       <= wr;
        i_mem_op          <= op;
        i_alu_result      <= alu;
        i_store_data      <= sd;
        i_reg_write       <= rw;
        i_mem_to_reg      <= m2r;
        i_selected_reg    <= sel;
        i_r31_ctrl        <= r31;
        i_pc              <= pc;
        i_hlt             <= hlt;
        i_rs_addr         <= last_sel;  // previous destination hits the bypass
        i_rt_addr         <= reg_addr_t'(lcg_next());
        last_sel = r31 ? reg_addr_t'(31) : sel;
    endtask

    task automatic bubble();
        present(1'b1, 1'b0, 1'b0, MEM_WORD, '0, '0, 1'b0, 1'b0, '0, 1'b0, '0, 1'b0);
    endtask

    task automatic alu_op(logic en);
        present(en, 1'b0, 1'b0, MEM_WORD, lcg_next(), '0, 1'b1, 1'b0,
                reg_addr_t'(lcg_next()), 1'b0, '0, 1'b0);
    endtask

    task automatic do_reset();
        @(posedge i_clock);
        i_reset <= 1'b1;
        bubble();
        repeat (4) @(posedge i_clock);
        i_reset <= 1'b0;
    endtask

    task automatic begin_test(string name);
        cur_test = name;
        test_errs_start = errors;
    endtask

    task automatic end_test();
        bubble();
        bubble();
        repeat (2) @(posedge i_clock);
        @(negedge i_clock);
        tests_run++;
        if (errors == test_errs_start) begin
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", cur_test, errors - test_errs_start);
        end
    endtask

    initial begin
        data_t      base;
        data_t      st_addr;
        data_t      ld_addr;
        mem_op_e    op;
        reg_addr_t  sel;

        repeat (5) @(posedge i_clock);
        i_reset <= 1'b0;

        begin_test("reset");
        for (int i = 0; i < 32; i++) begin
            @(posedge i_clock);
            i_rs_addr <= reg_addr_t'(i);
            i_rt_addr <= reg_addr_t'(31 - i);
        end
        end_test();

        begin_test("alu_writeback");
        for (int i = 0; i < 50; i++) begin
            sel = (i % 10 == 0) ? '0 : reg_addr_t'(lcg_next());    // r0 now and then
            present(1'b1, 1'b0, 1'b0, MEM_WORD, lcg_next(), '0, 1'b1, 1'b0, sel,
                    1'b0, '0, 1'b0);
        end
        end_test();

        begin_test("store_load");
        for (int i = 0; i < 16; i++) begin
            op      = mem_op_e'(lcg_next() % 5);
            st_addr = aligned_addr(op);
            base    = st_addr & 32'hffff_fffc;
            present(1'b1, 1'b0, 1'b1, op, st_addr, lcg_next(), 1'b0, 1'b0, '0,
                    1'b0, '0, 1'b0);
            for (int k = 0; k < 5; k++) begin
                op      = mem_op_e'(k);
                ld_addr = base + (aligned_addr(op) & 32'd3);
                sel     = reg_addr_t'(lcg_next() | 32'd1);
                present(1'b1, 1'b1, 1'b0, op, ld_addr, '0, 1'b1, 1'b1, sel,
                        1'b0, '0, 1'b0);
            end
        end
        end_test();

        begin_test("link");
        for (int i = 0; i < 15; i++) begin
            present(1'b1, seed[3], 1'b0, MEM_WORD, aligned_addr(MEM_WORD), lcg_next(),
                    1'b1, seed[5], reg_addr_t'(lcg_next()), 1'b1, lcg_next(), 1'b0);
        end
        end_test();

        begin_test("stall");
        st_addr = aligned_addr(MEM_WORD);
        present(1'b1, 1'b0, 1'b1, MEM_WORD, st_addr, lcg_next(), 1'b0, 1'b0, '0,
                1'b0, '0, 1'b0);
        alu_op(1'b1);
        for (int i = 0; i < 6; i++) begin
            if (i % 2 == 0) begin
                present(1'b0, 1'b0, 1'b1, MEM_WORD, st_addr, lcg_next(), 1'b0, 1'b0, '0,
                        1'b0, '0, 1'b0);
            end else begin
                alu_op(1'b0);
            end
        end
        present(1'b1, 1'b1, 1'b0, MEM_WORD, st_addr, '0, 1'b1, 1'b1, reg_addr_t'(7),
                1'b0, '0, 1'b0);
        alu_op(1'b1);
        end_test();

        begin_test("halt");
        alu_op(1'b1);
        present(1'b1, 1'b0, 1'b0, MEM_WORD, '0, '0, 1'b0, 1'b0, '0, 1'b0, '0, 1'b1);
        for (int i = 0; i < 8; i++) alu_op(1'b1);
        do_reset();
        repeat (3) bubble();
        end_test();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog: tests did not finish within %0d ns", TIMEOUT_NS);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
